//--- hdl/na_pkg.sv
/*
 * Network adapter package for compute tiles
 * Flit format, header field positions, bus widths, slave map
 * and register offsets shared by the adapter blocks
 */

package na_pkg;

   localparam int DATA_WIDTH = 32;                 // Bus data and flit data
   localparam int ADDR_WIDTH = 32;                 // Bus address

   // Flit kind on the link
   typedef enum logic [1:0] {
      PAYLOAD = 2'd0,                              // Body flit
      LAST    = 2'd1,                              // Closes a packet
      HEADER  = 2'd2,                              // Opens a packet
      SINGLE  = 2'd3                               // Header and last in one
   } flit_kind_t;

   typedef struct packed {
      flit_kind_t            kind;
      logic [DATA_WIDTH-1:0] data;
   } flit_t;                                       // 34 bits

   // Header word layout
   localparam int HDR_DEST_LSB  = 27;              // Destination 31:27
   localparam int HDR_CLASS_LSB = 24;              // Class 26:24
   localparam int HDR_CLASS_W   = 3;
   localparam int HDR_LEN_W     = 5;               // Payload flits 4:0

   localparam logic [HDR_CLASS_W-1:0] CLASS_MP = 3'd0;   // Message passing

   // Slave select, address bits 23:20
   localparam int         SLAVE_SEL_LSB = 20;
   localparam logic [3:0] SLAVE_CONF    = 4'd0;
   localparam logic [3:0] SLAVE_MP      = 4'd1;

   // Register offsets, address bits 3:0
   localparam logic [3:0] CONF_TILEID_OFS   = 4'h0;
   localparam logic [3:0] CONF_COREBASE_OFS = 4'h4;
   localparam logic [3:0] CONF_FEATURES_OFS = 4'h8;
   localparam logic [3:0] MP_DATA_OFS       = 4'h0;
   localparam logic [3:0] MP_STATUS_OFS     = 4'h4;

   localparam int FEAT_MP  = 0;                    // Features word bits
   localparam int FEAT_DMA = 1;

endpackage

//--- hdl/noc_buffer.sv
/*
 * NoC flit buffer
 * Circular FIFO with valid/ready on both sides, ready while not full
 */

module noc_buffer #(
   parameter int DEPTH = 4
) (
   input  logic          clk,
   input  logic          arst_n_i,
   input  na_pkg::flit_t in_flit_i,
   input  logic          in_valid_i,
   output logic          in_ready_o,
   output na_pkg::flit_t out_flit_o,
   output logic          out_valid_o,
   input  logic          out_ready_i
);
   import na_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   flit_t            mem_q [DEPTH];               // Flit storage
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;                     // Fill level
   logic             push;
   logic             pop;

   // Pointer step with wrap at DEPTH
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready_o  = (count_q != CNT_W'(DEPTH));   // Not full
   assign out_valid_o = (count_q != '0);              // Not empty
   assign out_flit_o  = mem_q[rd_ptr_q];              // Head of queue
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
         if (push && !pop) count_q <= count_q + 1'b1;
         else if (pop && !push) count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem_q[wr_ptr_q] <= in_flit_i;      // Visible from next cycle
   end

endmodule

//--- hdl/wb_slave_decode.sv
/*
 * Wishbone slave decode
 * Picks a slave by address bits 23:20, strobes it and muxes back
 * its read data and ack, answers unmapped indices with err
 */

module wb_slave_decode (
   input  logic                          clk,
   input  logic                          arst_n_i,
   // Master side
   input  logic [na_pkg::ADDR_WIDTH-1:0] m_adr_i,
   input  logic                          m_cyc_i,
   input  logic                          m_stb_i,
   output logic [na_pkg::DATA_WIDTH-1:0] m_dat_o,
   output logic                          m_ack_o,
   output logic                          m_err_o,
   // Slave side
   output logic                          conf_stb_o,
   output logic                          mp_stb_o,
   input  logic [na_pkg::DATA_WIDTH-1:0] conf_dat_i,
   input  logic                          conf_ack_i,
   input  logic [na_pkg::DATA_WIDTH-1:0] mp_dat_i,
   input  logic                          mp_ack_i
);
   import na_pkg::*;

   localparam int SEL_W = $bits(SLAVE_CONF);

   logic [SEL_W-1:0] slave_idx;
   logic             strobe;                       // cyc & stb
   logic             sel_conf;
   logic             sel_mp;
   logic             err_q;

   assign slave_idx  = m_adr_i[SLAVE_SEL_LSB +: SEL_W];
   assign strobe     = m_cyc_i & m_stb_i;
   assign sel_conf   = (slave_idx == SLAVE_CONF);
   assign sel_mp     = (slave_idx == SLAVE_MP);
   assign conf_stb_o = strobe & sel_conf;
   assign mp_stb_o   = strobe & sel_mp;

   // Return path of the addressed slave
   always_comb begin
      m_dat_o = '0;
      m_ack_o = 1'b0;
      if (sel_conf) begin
         m_dat_o = conf_dat_i;
         m_ack_o = conf_ack_i;
      end else if (sel_mp) begin
         m_dat_o = mp_dat_i;
         m_ack_o = mp_ack_i;
      end
   end

   // Unmapped index, err one cycle after stb, single pulse
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) err_q <= 1'b0;
      else err_q <= strobe & ~sel_conf & ~sel_mp & ~err_q;
   end

   assign m_err_o = err_q;

endmodule

//--- hdl/na_conf.sv
/*
 * Network adapter configuration slave
 * Read-only tile identity, core base and feature registers
 */

module na_conf #(
   parameter logic [na_pkg::DATA_WIDTH-1:0] TILEID   = '0,
   parameter logic [na_pkg::DATA_WIDTH-1:0] COREBASE = '0
) (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          stb_i,
   input  logic [3:0]                    adr_i,
   output logic [na_pkg::DATA_WIDTH-1:0] dat_o,
   output logic                          ack_o
);
   import na_pkg::*;

   logic [DATA_WIDTH-1:0] features;
   logic [DATA_WIDTH-1:0] rdata;
   logic [DATA_WIDTH-1:0] dat_q;                  // Registered read data
   logic                  ack_q;

   always_comb begin
      features           = '0;
      features[FEAT_MP]  = 1'b1;                   // Message passing present
      features[FEAT_DMA] = 1'b0;                   // No DMA engine
   end

   always_comb begin
      case (adr_i)
         CONF_TILEID_OFS:   rdata = TILEID;
         CONF_COREBASE_OFS: rdata = COREBASE;
         CONF_FEATURES_OFS: rdata = features;
         default:           rdata = '0;
      endcase
   end

   // One ack per strobe, writes fall through unchanged
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) ack_q <= 1'b0;
      else ack_q <= stb_i & ~ack_q;
   end

   always_ff @(posedge clk) begin
      dat_q <= rdata;
   end

   assign dat_o = dat_q;
   assign ack_o = ack_q;

endmodule

//--- hdl/mp_simple_wb.sv
/*
 * Simple message passing engine
 * Bus writes become flits of an outgoing packet, incoming flits are
 * queued for bus reads and flagged with an interrupt
 */

module mp_simple_wb #(
   parameter int MP_DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          arst_n_i,
   // Bus slave
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [3:0]                    adr_i,
   input  logic [na_pkg::DATA_WIDTH-1:0] dat_i,
   output logic [na_pkg::DATA_WIDTH-1:0] dat_o,
   output logic                          ack_o,
   // Send link
   output na_pkg::flit_t                 out_flit_o,
   output logic                          out_valid_o,
   input  logic                          out_ready_i,
   // Receive link
   input  na_pkg::flit_t                 in_flit_i,
   input  logic                          in_valid_i,
   output logic                          in_ready_o,
   output logic                          irq_o
);
   import na_pkg::*;

   flit_t                 send_flit;
   logic                  send_ready;
   flit_t                 recv_flit;
   logic                  recv_valid;
   logic                  wr_data;                 // Data register write
   logic                  rd_data;                 // Data register read
   logic                  access;                  // Access taken this edge
   logic                  push;
   logic                  pop;
   logic [HDR_LEN_W-1:0]  hdr_len;
   logic                  open_q;                  // Packet in progress
   logic [HDR_LEN_W-1:0]  remain_q;                // Flits still to come
   logic                  ack_q;
   logic                  irq_q;
   logic [DATA_WIDTH-1:0] dat_q;

   assign wr_data = stb_i & we_i & (adr_i == MP_DATA_OFS);
   assign rd_data = stb_i & ~we_i & (adr_i == MP_DATA_OFS);
   assign access  = stb_i & ~ack_q & (~wr_data | send_ready);   // Full queue stalls
   assign push    = access & wr_data;
   assign pop     = access & rd_data;
   assign hdr_len = dat_i[HDR_LEN_W-1:0];

   // Kind from packet state
   always_comb begin
      send_flit.data = dat_i;
      if (!open_q) send_flit.kind = (hdr_len == '0) ? SINGLE : HEADER;
      else if (remain_q == HDR_LEN_W'(1)) send_flit.kind = LAST;
      else send_flit.kind = PAYLOAD;
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         open_q   <= 1'b0;
         remain_q <= '0;
         ack_q    <= 1'b0;
         irq_q    <= 1'b0;
      end else begin
         ack_q <= access;
         irq_q <= recv_valid;                      // Receive not empty
         if (push) begin
            if (!open_q) begin
               open_q   <= (hdr_len != '0);
               remain_q <= hdr_len;
            end else begin
               remain_q <= remain_q - 1'b1;
               if (remain_q == HDR_LEN_W'(1)) open_q <= 1'b0;
            end
         end
      end
   end

   // Read data for the ack cycle
   always_ff @(posedge clk) begin
      if (access && !we_i) begin
         if (adr_i == MP_STATUS_OFS) dat_q <= {{(DATA_WIDTH-2){1'b0}}, open_q, recv_valid};
         else if (rd_data) dat_q <= recv_valid ? recv_flit.data : '0;   // Empty reads 0
         else dat_q <= '0;
      end
   end

   assign dat_o = dat_q;
   assign ack_o = ack_q;
   assign irq_o = irq_q;

   noc_buffer #(.DEPTH(MP_DEPTH)) u_sendq (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_flit_i   (send_flit),
      .in_valid_i  (push),
      .in_ready_o  (send_ready),
      .out_flit_o  (out_flit_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   noc_buffer #(.DEPTH(MP_DEPTH)) u_recvq (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_flit_i   (in_flit_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_flit_o  (recv_flit),
      .out_valid_o (recv_valid),
      .out_ready_i (pop)                           // One entry per data read
   );

endmodule

//--- hdl/noc_class_filter.sv
/*
 * NoC class filter
 * Forwards message passing packets, swallows packets of other classes
 */

module noc_class_filter (
   input  logic          clk,
   input  logic          arst_n_i,
   input  na_pkg::flit_t in_flit_i,
   input  logic          in_valid_i,
   output logic          in_ready_o,
   output na_pkg::flit_t out_flit_o,
   output logic          out_valid_o,
   input  logic          out_ready_i
);
   import na_pkg::*;

   logic                   is_head;                // HEADER or SINGLE
   logic [HDR_CLASS_W-1:0] flit_class;
   logic                   drop;                   // Discard this flit
   logic                   drop_q;                 // Inside a dropped packet

   assign is_head    = (in_flit_i.kind == HEADER) || (in_flit_i.kind == SINGLE);
   assign flit_class = in_flit_i.data[HDR_CLASS_LSB +: HDR_CLASS_W];
   assign drop       = is_head ? (flit_class != CLASS_MP) : drop_q;

   assign out_flit_o  = in_flit_i;
   assign out_valid_o = in_valid_i & ~drop;
   assign in_ready_o  = drop | out_ready_i;       // Dropped flits always taken

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) drop_q <= 1'b0;
      else if (in_valid_i && in_ready_o) begin
         if (in_flit_i.kind == HEADER) drop_q <= (flit_class != CLASS_MP);
         else if (in_flit_i.kind == LAST) drop_q <= 1'b0;   // Packet closed
      end
   end

endmodule

//--- hdl/networkadapter_ct.sv
/*
 * Compute tile network adapter
 * Bus slave decode, configuration and message passing slaves,
 * NoC in and out buffers and the class filter on the input path
 */

module networkadapter_ct #(
   parameter logic [na_pkg::DATA_WIDTH-1:0] TILEID   = '0,
   parameter logic [na_pkg::DATA_WIDTH-1:0] COREBASE = '0,
   parameter int IN_DEPTH  = 4,
   parameter int OUT_DEPTH = 4,
   parameter int MP_DEPTH  = 8
) (
   input  logic                          clk,
   input  logic                          arst_n_i,
   // NoC
   input  na_pkg::flit_t                 noc_in_flit_i,
   input  logic                          noc_in_valid_i,
   output logic                          noc_in_ready_o,
   output na_pkg::flit_t                 noc_out_flit_o,
   output logic                          noc_out_valid_o,
   input  logic                          noc_out_ready_i,
   // Wishbone slave
   input  logic [na_pkg::ADDR_WIDTH-1:0] wbs_adr_i,
   input  logic [na_pkg::DATA_WIDTH-1:0] wbs_dat_i,
   input  logic [3:0]                    wbs_sel_i,
   input  logic                          wbs_we_i,
   input  logic                          wbs_cyc_i,
   input  logic                          wbs_stb_i,
   output logic [na_pkg::DATA_WIDTH-1:0] wbs_dat_o,
   output logic                          wbs_ack_o,
   output logic                          wbs_err_o,
   output logic                          irq_o
);
   import na_pkg::*;

   logic                  conf_stb;
   logic                  conf_ack;
   logic                  mp_stb;
   logic                  mp_ack;
   logic [DATA_WIDTH-1:0] conf_dat;
   logic [DATA_WIDTH-1:0] mp_dat;
   logic [DATA_WIDTH-1:0] wr_dat;                 // Byte lanes masked by sel
   flit_t                 inbuf_flit;
   flit_t                 filt_flit;
   flit_t                 mp_out_flit;
   logic                  inbuf_valid;
   logic                  inbuf_ready;
   logic                  filt_valid;
   logic                  filt_ready;
   logic                  mp_out_valid;
   logic                  mp_out_ready;

   always_comb begin
      for (int b = 0; b < DATA_WIDTH / 8; b++) begin
         wr_dat[b*8 +: 8] = wbs_dat_i[b*8 +: 8] & {8{wbs_sel_i[b]}};
      end
   end

   wb_slave_decode u_slavedecode (
      .clk (clk), .arst_n_i (arst_n_i),
      .m_adr_i (wbs_adr_i), .m_cyc_i (wbs_cyc_i), .m_stb_i (wbs_stb_i),
      .m_dat_o (wbs_dat_o), .m_ack_o (wbs_ack_o), .m_err_o (wbs_err_o),
      .conf_stb_o (conf_stb), .mp_stb_o (mp_stb),
      .conf_dat_i (conf_dat), .conf_ack_i (conf_ack),
      .mp_dat_i (mp_dat), .mp_ack_i (mp_ack)
   );

   na_conf #(.TILEID(TILEID), .COREBASE(COREBASE)) u_conf (
      .clk (clk), .arst_n_i (arst_n_i), .stb_i (conf_stb),
      .adr_i (wbs_adr_i[3:0]), .dat_o (conf_dat), .ack_o (conf_ack)
   );

   mp_simple_wb #(.MP_DEPTH(MP_DEPTH)) u_mp_simple (
      .clk (clk), .arst_n_i (arst_n_i),
      .stb_i (mp_stb), .we_i (wbs_we_i), .adr_i (wbs_adr_i[3:0]),
      .dat_i (wr_dat), .dat_o (mp_dat), .ack_o (mp_ack),
      .out_flit_o (mp_out_flit), .out_valid_o (mp_out_valid), .out_ready_i (mp_out_ready),
      .in_flit_i (filt_flit), .in_valid_i (filt_valid), .in_ready_o (filt_ready),
      .irq_o (irq_o)
   );

   noc_buffer #(.DEPTH(IN_DEPTH)) u_inbuffer (
      .clk (clk), .arst_n_i (arst_n_i),
      .in_flit_i (noc_in_flit_i), .in_valid_i (noc_in_valid_i), .in_ready_o (noc_in_ready_o),
      .out_flit_o (inbuf_flit), .out_valid_o (inbuf_valid), .out_ready_i (inbuf_ready)
   );

   noc_class_filter u_filter (
      .clk (clk), .arst_n_i (arst_n_i),
      .in_flit_i (inbuf_flit), .in_valid_i (inbuf_valid), .in_ready_o (inbuf_ready),
      .out_flit_o (filt_flit), .out_valid_o (filt_valid), .out_ready_i (filt_ready)
   );

   noc_buffer #(.DEPTH(OUT_DEPTH)) u_outbuffer (
      .clk (clk), .arst_n_i (arst_n_i),
      .in_flit_i (mp_out_flit), .in_valid_i (mp_out_valid), .in_ready_o (mp_out_ready),
      .out_flit_o (noc_out_flit_o), .out_valid_o (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i)
   );

endmodule

//--- tb/networkadapter_ct_assert.sv
/*
 * Protocol checks for the compute tile network adapter
 * NoC output stability under back-pressure and bus response rules
 */

module networkadapter_ct_assert (
   input logic          clk,
   input logic          arst_n_i,
   input na_pkg::flit_t noc_out_flit_i,
   input logic          noc_out_valid_i,
   input logic          noc_out_ready_i,
   input logic          wbs_stb_i,
   input logic          wbs_ack_i,
   input logic          wbs_err_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Stalled flit stays put until taken
   a_out_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      (noc_out_valid_i && !noc_out_ready_i) |=> (noc_out_valid_i && $stable(noc_out_flit_i)))
      else $error("NoC output flit or valid changed while stalled");

   a_ack_err: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(wbs_ack_i && wbs_err_i))
      else $error("Bus ack and err high together");   // Exclusive responses

   a_resp_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
      (wbs_ack_i || wbs_err_i) |-> wbs_stb_i)
      else $error("Bus response without strobe");

endmodule

bind networkadapter_ct networkadapter_ct_assert u_assert (
   .clk             (clk),
   .arst_n_i        (arst_n_i),
   .noc_out_flit_i  (noc_out_flit_o),
   .noc_out_valid_i (noc_out_valid_o),
   .noc_out_ready_i (noc_out_ready_i),
   .wbs_stb_i       (wbs_stb_i),
   .wbs_ack_i       (wbs_ack_o),
   .wbs_err_i       (wbs_err_o)
);

//--- tb/tb_networkadapter_ct.sv
/*
 * Testbench for the compute tile network adapter
 * Table of bus accesses, NoC injections and expected responses,
 * random NoC output back-pressure from an LFSR
 */

module tb_networkadapter_ct;
   timeunit 1ns;
   timeprecision 100ps;
   import na_pkg::*;

   localparam logic [31:0] TILEID    = 32'h0000_0005;
   localparam logic [31:0] COREBASE  = 32'h8000_0000;
   localparam int          IN_DEPTH  = 4;
   localparam int          OUT_DEPTH = 4;
   localparam int          MP_DEPTH  = 8;
   localparam int          BIG_LEN   = MP_DEPTH + OUT_DEPTH;   // Overflows both queues
   localparam int          RESET_CYCLES = 8;
   localparam int          STALL_CYCLES = 16;
   localparam logic [31:0] CONF_BASE = 32'h0000_0000;       // Slave index 0
   localparam logic [31:0] MP_BASE   = 32'h0010_0000;       // Slave index 1
   localparam logic [31:0] BAD_BASE  = 32'h0030_0000;       // Unmapped index 3
   localparam int OP_WR      = 0;
   localparam int OP_RD      = 1;
   localparam int OP_ERR     = 2;
   localparam int OP_INJ     = 3;
   localparam int OP_OUT     = 4;
   localparam int OP_IRQ     = 5;
   localparam int OP_HOLD    = 6;
   localparam int OP_WRSTALL = 7;

   typedef struct {
      int          op;
      logic [31:0] adr;
      logic [31:0] dat;                            // Write, expected or level
      flit_kind_t  kind;
   } row_t;

   logic        clk;
   logic        arst_n_i;
   flit_t       noc_in_flit_i;
   logic        noc_in_valid_i;
   logic        noc_in_ready_o;
   flit_t       noc_out_flit_o;
   logic        noc_out_valid_o;
   logic        noc_out_ready_i;
   logic [31:0] wbs_adr_i;
   logic [31:0] wbs_dat_i;
   logic [3:0]  wbs_sel_i;
   logic        wbs_we_i;
   logic        wbs_cyc_i;
   logic        wbs_stb_i;
   logic [31:0] wbs_dat_o;
   logic        wbs_ack_o;
   logic        wbs_err_o;
   logic        irq_o;
   row_t        rows[$];                           // Stimulus table
   flit_t       out_q[$];                          // Flits taken from the NoC output
   logic [31:0] lfsr_q = 32'hf9ef;
   logic        hold_ready;                        // Forces output ready low
   int          cycles = 0;
   int          limit_cycles = 1_000_000;
   string       waiting_for = "reset";

   networkadapter_ct #(
      .TILEID (TILEID), .COREBASE (COREBASE),
      .IN_DEPTH (IN_DEPTH), .OUT_DEPTH (OUT_DEPTH), .MP_DEPTH (MP_DEPTH)
   ) uut (
      .clk (clk), .arst_n_i (arst_n_i),
      .noc_in_flit_i (noc_in_flit_i), .noc_in_valid_i (noc_in_valid_i),
      .noc_in_ready_o (noc_in_ready_o),
      .noc_out_flit_o (noc_out_flit_o), .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .wbs_adr_i (wbs_adr_i), .wbs_dat_i (wbs_dat_i), .wbs_sel_i (wbs_sel_i),
      .wbs_we_i (wbs_we_i), .wbs_cyc_i (wbs_cyc_i), .wbs_stb_i (wbs_stb_i),
      .wbs_dat_o (wbs_dat_o), .wbs_ack_o (wbs_ack_o), .wbs_err_o (wbs_err_o),
      .irq_o (irq_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                      // 40 ns period
   end

   // Galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[0];
      s = s >> 1;
      if (fb) s = s ^ 32'h8020_0003;
      return s;
   endfunction

   // Header word with dest 31:27, class 26:24 and length 4:0
   function automatic logic [31:0] make_hdr(input logic [4:0] dest, input logic [2:0] cls,
                                            input logic [4:0] len);
      return {dest, cls, 19'b0, len};
   endfunction

   function automatic void add_row(input int op, input logic [31:0] adr,
                                   input logic [31:0] dat, input flit_kind_t kind);
      rows.push_back('{op, adr, dat, kind});
   endfunction

   always @(posedge clk) begin
      lfsr_q = lfsr_step(lfsr_q);                  // One step per bit taken
      noc_out_ready_i <= hold_ready ? 1'b0 : lfsr_q[0];
   end

   // NoC output monitor for transfers on the coming edge
   always @(negedge clk) begin
      if (arst_n_i && noc_out_valid_o && noc_out_ready_i) out_q.push_back(noc_out_flit_o);
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit_cycles) begin
         $display("Timeout after %0d cycles while waiting for %s", cycles, waiting_for);
         $display("Test failed");
         $fatal(1, "Simulation stopped on timeout");
      end
   end

   task automatic check_value(input string name, input logic [33:0] exp,
                              input logic [33:0] got);
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Single beat access with an optional stall window before output release
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             input int stall, output logic [31:0] rdat, output logic ack,
                             output logic err);
      @(posedge clk);
      wbs_adr_i <= adr;
      wbs_dat_i <= wdat;
      wbs_we_i  <= we;
      wbs_cyc_i <= 1'b1;
      wbs_stb_i <= 1'b1;
      waiting_for = "a bus response";
      repeat (stall) begin
         @(negedge clk);
         check_value("wbs_ack_o", 0, wbs_ack_o);   // Held back by full queues
      end
      if (stall > 0) hold_ready = 1'b0;
      @(negedge clk);
      while (!wbs_ack_o && !wbs_err_o) @(negedge clk);
      rdat = wbs_dat_o;
      ack  = wbs_ack_o;
      err  = wbs_err_o;
      @(posedge clk);
      wbs_cyc_i <= 1'b0;
      wbs_stb_i <= 1'b0;
      wbs_we_i  <= 1'b0;
   endtask

   task automatic inject_flit(input flit_kind_t k, input logic [31:0] dat);
      flit_t f;
      f.kind = k;
      f.data = dat;
      @(posedge clk);
      noc_in_flit_i  <= f;
      noc_in_valid_i <= 1'b1;
      waiting_for = "noc_in_ready_o";
      @(negedge clk);
      while (!noc_in_ready_o) @(negedge clk);
      @(posedge clk);                              // Taken on this edge
      noc_in_valid_i <= 1'b0;
   endtask

   task automatic expect_out_flit(input flit_kind_t k, input logic [31:0] dat);
      flit_t f;
      waiting_for = "a NoC output flit";
      while (out_q.size() == 0) @(negedge clk);
      f = out_q.pop_front();
      check_value("noc_out_flit_o.kind", k, f.kind);
      check_value("noc_out_flit_o.data", dat, f.data);
   endtask

   task automatic wait_irq(input logic level);
      waiting_for = "irq_o to reach its expected level";
      @(negedge clk);
      while (irq_o !== level) @(negedge clk);
   endtask

   task automatic apply_row(input row_t r);
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      case (r.op)
         OP_WR, OP_WRSTALL: begin
            bus_access(1'b1, r.adr, r.dat, (r.op == OP_WRSTALL) ? STALL_CYCLES : 0,
                       rdat, ack, err);
            check_value("wbs_ack_o", 1, ack);
            check_value("wbs_err_o", 0, err);
         end
         OP_RD: begin
            bus_access(1'b0, r.adr, '0, 0, rdat, ack, err);
            check_value("wbs_ack_o", 1, ack);
            check_value("wbs_dat_o", r.dat, rdat);
         end
         OP_ERR: begin
            bus_access(1'b0, r.adr, '0, 0, rdat, ack, err);
            check_value("wbs_err_o", 1, err);
            check_value("wbs_ack_o", 0, ack);
         end
         OP_INJ: inject_flit(r.kind, r.dat);
         OP_OUT: expect_out_flit(r.kind, r.dat);
         OP_IRQ: wait_irq(r.dat[0]);
         default: begin
            @(negedge clk);                        // Clear of the sampling edge
            hold_ready = r.dat[0];
         end
      endcase
   endtask

   task automatic build_table();
      add_row(OP_RD, CONF_BASE | 32'h0, TILEID, PAYLOAD);       // Configuration words
      add_row(OP_RD, CONF_BASE | 32'h4, COREBASE, PAYLOAD);
      add_row(OP_RD, CONF_BASE | 32'h8, 32'h1, PAYLOAD);        // Only the MP feature
      add_row(OP_ERR, BAD_BASE, '0, PAYLOAD);
      add_row(OP_WR, MP_BASE, make_hdr(5'd2, CLASS_MP, 5'd2), PAYLOAD);
      add_row(OP_RD, MP_BASE | 32'h4, 32'h2, PAYLOAD);          // Packet open
      add_row(OP_WR, MP_BASE, 32'hcafe_0001, PAYLOAD);
      add_row(OP_WR, MP_BASE, 32'hcafe_0002, PAYLOAD);
      add_row(OP_WR, MP_BASE, make_hdr(5'd7, CLASS_MP, 5'd0), PAYLOAD);
      add_row(OP_OUT, '0, make_hdr(5'd2, CLASS_MP, 5'd2), HEADER);
      add_row(OP_OUT, '0, 32'hcafe_0001, PAYLOAD);
      add_row(OP_OUT, '0, 32'hcafe_0002, LAST);
      add_row(OP_OUT, '0, make_hdr(5'd7, CLASS_MP, 5'd0), SINGLE);
      add_row(OP_INJ, '0, make_hdr(5'd3, CLASS_MP, 5'd2), HEADER);   // Receive path
      add_row(OP_INJ, '0, 32'h1234_5678, PAYLOAD);
      add_row(OP_INJ, '0, 32'h9abc_def0, LAST);
      add_row(OP_IRQ, '0, 32'h1, PAYLOAD);
      add_row(OP_RD, MP_BASE | 32'h4, 32'h1, PAYLOAD);          // Receive not empty
      add_row(OP_RD, MP_BASE, make_hdr(5'd3, CLASS_MP, 5'd2), PAYLOAD);
      add_row(OP_RD, MP_BASE, 32'h1234_5678, PAYLOAD);
      add_row(OP_RD, MP_BASE, 32'h9abc_def0, PAYLOAD);
      add_row(OP_RD, MP_BASE | 32'h4, 32'h0, PAYLOAD);          // Empty and no packet open
      add_row(OP_IRQ, '0, 32'h0, PAYLOAD);
      add_row(OP_INJ, '0, make_hdr(5'd3, 3'd2, 5'd1), HEADER);    // Class 2 is dropped
      add_row(OP_INJ, '0, 32'hdead_beef, LAST);
      add_row(OP_INJ, '0, make_hdr(5'd4, CLASS_MP, 5'd0), SINGLE);
      add_row(OP_IRQ, '0, 32'h1, PAYLOAD);
      add_row(OP_RD, MP_BASE, make_hdr(5'd4, CLASS_MP, 5'd0), PAYLOAD);
      add_row(OP_RD, MP_BASE, 32'h0, PAYLOAD);
      add_row(OP_IRQ, '0, 32'h0, PAYLOAD);
      add_row(OP_HOLD, '0, 32'h1, PAYLOAD);                    // Output blocked
      add_row(OP_WR, MP_BASE, make_hdr(5'd1, CLASS_MP, 5'(BIG_LEN)), PAYLOAD);
      for (int i = 1; i < BIG_LEN; i++) add_row(OP_WR, MP_BASE, 32'h6000_0000 + i, PAYLOAD);
      add_row(OP_WRSTALL, MP_BASE, 32'h6000_0000 + BIG_LEN, PAYLOAD);
      add_row(OP_OUT, '0, make_hdr(5'd1, CLASS_MP, 5'(BIG_LEN)), HEADER);
      for (int i = 1; i < BIG_LEN; i++) add_row(OP_OUT, '0, 32'h6000_0000 + i, PAYLOAD);
      add_row(OP_OUT, '0, 32'h6000_0000 + BIG_LEN, LAST);
   endtask

   initial begin
      arst_n_i       = 1'b0;
      noc_in_flit_i  = '0;
      noc_in_valid_i = 1'b0;
      noc_out_ready_i = 1'b0;
      wbs_adr_i      = '0;
      wbs_dat_i      = '0;
      wbs_sel_i      = 4'hf;                       // Full words only
      wbs_we_i       = 1'b0;
      wbs_cyc_i      = 1'b0;
      wbs_stb_i      = 1'b0;
      hold_ready     = 1'b0;
      build_table();
      limit_cycles = rows.size() * 64 + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      check_value("noc_out_valid_o", 0, noc_out_valid_o);      // Idle after reset
      check_value("noc_in_ready_o", 1, noc_in_ready_o);
      check_value("wbs_ack_o", 0, wbs_ack_o);
      check_value("wbs_err_o", 0, wbs_err_o);
      check_value("irq_o", 0, irq_o);
      foreach (rows[i]) apply_row(rows[i]);
      repeat (4) @(negedge clk);
      assert (out_q.size() == 0) else begin
         $display("Extra flits appeared at the NoC output after the last expected one");
         $display("Test failed");
         $fatal(1, "Unexpected NoC output");
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- networkadapter_ct.f
hdl/na_pkg.sv
hdl/noc_buffer.sv
hdl/wb_slave_decode.sv
hdl/na_conf.sv
hdl/mp_simple_wb.sv
hdl/noc_class_filter.sv
hdl/networkadapter_ct.sv
tb/networkadapter_ct_assert.sv
tb/tb_networkadapter_ct.sv
